// ==== hyper_pkg.sv ====
// shared widths, command-address word and phy state encoding
// imported by the hyperbus controller modules and the ram model
`default_nettype none

package hyper_pkg;

    localparam int unsigned WORD_W = 16;  // one bus word per clk0 cycle
    localparam int unsigned ADDR_W = 32;  // word address of a transaction

    // command-address word, built as fields and sent as beats
    typedef union packed {
        struct packed {
            logic              rw;          // 1 for read
            logic              addr_space;  // 0 memory, 1 register space
            logic              burst_type;  // 1 linear burst
            logic [ADDR_W-4:0] addr_hi;     // row and upper column
            logic [12:0]       reserved;
            logic [2:0]        addr_lo;     // lower column
        } fields;
        logic [2:0][WORD_W-1:0] beats;      // beats[2] goes out first
    } hyper_ca_t;

    typedef enum logic [2:0] {
        IDLE,
        CMD_ADDR,
        LATENCY1,  // doubled initial latency, first half
        LATENCY2,
        DATA_W,
        DATA_R,
        RECOVER    // cs high before the next frame
    } hyper_state_e;

endpackage

`default_nettype wire

// ==== hyper_rx_fifo.sv ====
// receive fifo between bus capture and the read channel
// ready_o is the not-full level seen by the phy
`timescale 1ns/1ps
`default_nettype none

module hyper_rx_fifo import hyper_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 8
) (
    input  logic              clk0,
    input  logic              rst_ni,
    input  logic              push_i,
    input  logic [WORD_W-1:0] push_data_i,
    output logic              ready_o,
    output logic              valid_o,
    input  logic              ready_i,
    output logic [WORD_W-1:0] data_o
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

    logic [WORD_W-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
    logic [PTR_W:0]    count_q;
    logic              pop;

    assign valid_o = (count_q != '0);
    assign ready_o = (count_q != (PTR_W + 1)'(FIFO_DEPTH));
    assign data_o  = mem_q[rd_ptr_q];
    assign pop     = valid_o && ready_i;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + push_i - pop;  // both may happen together
        end
    end

    always_ff @(posedge clk0) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hyper_arbiter.sv ====
// round-robin arbiter putting two requester ports onto one hyperbus phy
// grant holds from acceptance until done; read data goes back to its owner
`timescale 1ns/1ps
`default_nettype none

module hyper_arbiter import hyper_pkg::*; #(
    parameter int unsigned ADDR_W  = 32,
    parameter int unsigned BURST_W = 12,
    parameter int unsigned NR_CS   = 2
) (
    input  logic               clk0,
    input  logic               rst_ni,
    // port 0
    input  logic               trans_valid_0_i,
    output logic               trans_ready_0_o,
    input  logic [ADDR_W-1:0]  trans_addr_0_i,
    input  logic [NR_CS-1:0]   trans_cs_0_i,
    input  logic               trans_write_0_i,
    input  logic [BURST_W-1:0] trans_burst_0_i,
    input  logic               tx_valid_0_i,
    output logic               tx_ready_0_o,
    input  logic [WORD_W-1:0]  tx_data_0_i,
    input  logic [1:0]         tx_strb_0_i,
    output logic               rx_valid_0_o,
    input  logic               rx_ready_0_i,
    output logic [WORD_W-1:0]  rx_data_0_o,
    // port 1
    input  logic               trans_valid_1_i,
    output logic               trans_ready_1_o,
    input  logic [ADDR_W-1:0]  trans_addr_1_i,
    input  logic [NR_CS-1:0]   trans_cs_1_i,
    input  logic               trans_write_1_i,
    input  logic [BURST_W-1:0] trans_burst_1_i,
    input  logic               tx_valid_1_i,
    output logic               tx_ready_1_o,
    input  logic [WORD_W-1:0]  tx_data_1_i,
    input  logic [1:0]         tx_strb_1_i,
    output logic               rx_valid_1_o,
    input  logic               rx_ready_1_i,
    output logic [WORD_W-1:0]  rx_data_1_o,
    // phy and fifo side
    output logic               phy_trans_valid_o,
    input  logic               phy_trans_ready_i,
    output logic [ADDR_W-1:0]  phy_addr_o,
    output logic [NR_CS-1:0]   phy_cs_o,
    output logic               phy_write_o,
    output logic [BURST_W-1:0] phy_burst_o,
    output logic               phy_tx_valid_o,
    input  logic               phy_tx_ready_i,
    output logic [WORD_W-1:0]  phy_tx_data_o,
    output logic [1:0]         phy_tx_strb_o,
    input  logic               fifo_valid_i,
    output logic               fifo_ready_o,
    input  logic [WORD_W-1:0]  fifo_data_i,
    input  logic               done_i
);

    logic       prio_q;    // port that wins a tie
    logic       locked_q;  // phy busy with grant_q
    logic       grant_q;
    logic       owner_q;   // port of the last accepted read
    logic [1:0] elig;
    logic       pick;
    logic       accept;

    // a read waits until the fifo has drained to the previous owner
    assign elig[0] = trans_valid_0_i && (trans_write_0_i || !fifo_valid_i);
    assign elig[1] = trans_valid_1_i && (trans_write_1_i || !fifo_valid_i);
    assign pick    = elig[prio_q] ? prio_q : ~prio_q;

    // trans channel, no added cycle
    assign phy_trans_valid_o = !locked_q && elig[pick];
    assign accept            = phy_trans_valid_o && phy_trans_ready_i;
    assign trans_ready_0_o   = accept && !pick;
    assign trans_ready_1_o   = accept && pick;
    assign phy_addr_o        = pick ? trans_addr_1_i : trans_addr_0_i;
    assign phy_cs_o          = pick ? trans_cs_1_i : trans_cs_0_i;
    assign phy_write_o       = pick ? trans_write_1_i : trans_write_0_i;
    assign phy_burst_o       = pick ? trans_burst_1_i : trans_burst_0_i;

    // write data follows the locked grant
    assign phy_tx_valid_o = locked_q && (grant_q ? tx_valid_1_i : tx_valid_0_i);
    assign phy_tx_data_o  = grant_q ? tx_data_1_i : tx_data_0_i;
    assign phy_tx_strb_o  = grant_q ? tx_strb_1_i : tx_strb_0_i;
    assign tx_ready_0_o   = phy_tx_ready_i && locked_q && !grant_q;
    assign tx_ready_1_o   = phy_tx_ready_i && locked_q && grant_q;

    // fifo output steered to the owner only
    assign rx_valid_0_o = fifo_valid_i && !owner_q;
    assign rx_valid_1_o = fifo_valid_i && owner_q;
    assign rx_data_0_o  = fifo_data_i;
    assign rx_data_1_o  = fifo_data_i;
    assign fifo_ready_o = owner_q ? rx_ready_1_i : rx_ready_0_i;

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q   <= 1'b0;
            locked_q <= 1'b0;
            grant_q  <= 1'b0;
            owner_q  <= 1'b0;
        end else if (accept) begin
            locked_q <= 1'b1;
            grant_q  <= pick;
            prio_q   <= ~pick;  // other port first next time
            if (!phy_write_o) begin
                owner_q <= pick;
            end
        end else if (done_i) begin
            locked_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hyper_phy.sv ====
// hyperbus phy: command-address beats, doubled latency, burst data, recovery
// one 16-bit word per clk0 cycle, bus clock given as a clock enable
`timescale 1ns/1ps
`default_nettype none

module hyper_phy import hyper_pkg::*; #(
    parameter int unsigned BURST_W     = 12,
    parameter int unsigned NR_CS       = 2,
    parameter int unsigned WAIT_CYCLES = 6
) (
    input  logic               clk0,
    input  logic               rst_ni,
    input  logic               trans_valid_i,
    output logic               trans_ready_o,
    input  logic [ADDR_W-1:0]  trans_addr_i,
    input  logic [NR_CS-1:0]   trans_cs_i,
    input  logic               trans_write_i,
    input  logic [BURST_W-1:0] trans_burst_i,
    input  logic               tx_valid_i,
    output logic               tx_ready_o,
    input  logic [WORD_W-1:0]  tx_data_i,
    input  logic [1:0]         tx_strb_i,
    output logic               push_o,
    output logic [WORD_W-1:0]  push_data_o,
    input  logic               fifo_ready_i,
    output logic               done_o,
    // hyperbus
    output logic [NR_CS-1:0]   hyper_cs_no,
    output logic               hyper_ck_en_o,
    output logic [WORD_W-1:0]  hyper_dq_o,
    input  logic [WORD_W-1:0]  hyper_dq_i,
    output logic               hyper_dq_oe_o,
    output logic [1:0]         hyper_rwds_o,
    input  logic [1:0]         hyper_rwds_i,
    output logic               hyper_rwds_oe_o
);

    // also counts the three ca beats, so it must hold 2
    localparam int unsigned CNT_W = $clog2(WAIT_CYCLES + 3);

    hyper_state_e       state_q, state_d;
    logic [CNT_W-1:0]   cnt_q, cnt_d;
    logic [BURST_W-1:0] burst_cnt_q, burst_cnt_d;  // words left minus one
    logic               accept;
    logic               in_frame;
    logic [ADDR_W-1:0]  addr_q;
    logic [NR_CS-1:0]   cs_q;
    logic               write_q;
    hyper_ca_t          ca;

    assign accept = trans_valid_i && trans_ready_o;

    always_comb begin
        ca                  = '0;
        ca.fields.rw        = ~write_q;
        ca.fields.burst_type = 1'b1;
        ca.fields.addr_hi   = addr_q[ADDR_W-1:3];
        ca.fields.addr_lo   = addr_q[2:0];
    end

    always_comb begin
        state_d     = state_q;
        cnt_d       = cnt_q;
        burst_cnt_d = burst_cnt_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d     = CMD_ADDR;
                    cnt_d       = CNT_W'(2);  // beat index, msb beat first
                    burst_cnt_d = trans_burst_i - 1'b1;
                end
            end
            CMD_ADDR, LATENCY1, LATENCY2: begin
                cnt_d = cnt_q - 1'b1;
                if (cnt_q == '0) begin
                    cnt_d = CNT_W'(WAIT_CYCLES - 1);
                    if (state_q == CMD_ADDR) begin
                        state_d = LATENCY1;
                    end else if (state_q == LATENCY1) begin
                        state_d = LATENCY2;
                    end else begin
                        state_d = write_q ? DATA_W : DATA_R;
                    end
                end
            end
            DATA_W, DATA_R: begin
                // a word moves only on a clocked cycle
                if (hyper_ck_en_o) begin
                    burst_cnt_d = burst_cnt_q - 1'b1;
                    if (burst_cnt_q == '0) begin
                        state_d = RECOVER;
                        cnt_d   = CNT_W'(WAIT_CYCLES - 1);
                    end
                end
            end
            RECOVER: begin
                cnt_d = cnt_q - 1'b1;
                if (cnt_q == '0) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= IDLE;
            cnt_q         <= '0;
            burst_cnt_q   <= '0;
            trans_ready_o <= 1'b0;
        end else begin
            state_q       <= state_d;
            cnt_q         <= cnt_d;
            burst_cnt_q   <= burst_cnt_d;
            trans_ready_o <= (state_d == IDLE);
        end
    end

    // local copy of the accepted transaction
    always_ff @(posedge clk0) begin
        if (accept) begin
            addr_q  <= trans_addr_i;
            cs_q    <= trans_cs_i;
            write_q <= trans_write_i;
        end
    end

    assign in_frame    = state_q inside {CMD_ADDR, LATENCY1, LATENCY2, DATA_W, DATA_R};
    assign hyper_cs_no = in_frame ? ~cs_q : '1;

    always_comb begin
        case (state_q)
            CMD_ADDR, LATENCY1, LATENCY2: hyper_ck_en_o = 1'b1;
            DATA_W:  hyper_ck_en_o = tx_valid_i;    // stall without write data
            DATA_R:  hyper_ck_en_o = fifo_ready_i;  // stall on a full fifo
            default: hyper_ck_en_o = 1'b0;
        endcase
    end

    assign hyper_dq_oe_o   = state_q inside {CMD_ADDR, DATA_W};
    assign hyper_rwds_oe_o = (state_q == DATA_W);
    assign hyper_rwds_o    = (state_q == DATA_W) ? ~tx_strb_i : 2'b00;  // mask
    assign hyper_dq_o      = (state_q == DATA_W)   ? tx_data_i :
                             (state_q == CMD_ADDR) ? ca.beats[cnt_q[1:0]] : '0;
    assign tx_ready_o      = (state_q == DATA_W);

    // capture only words the ram marks with rwds
    assign push_o      = (state_q == DATA_R) && fifo_ready_i && (|hyper_rwds_i);
    assign push_data_o = hyper_dq_i;
    assign done_o      = (state_q == RECOVER) && (cnt_q == '0);

endmodule

`default_nettype wire

// ==== hyper_subsystem.sv ====
// hyperbus controller top: two requester ports, arbiter, phy and receive fifo
// parameters set here reach every block below
`timescale 1ns/1ps
`default_nettype none

module hyper_subsystem import hyper_pkg::*; #(
    parameter int unsigned BURST_W     = 12,
    parameter int unsigned NR_CS       = 2,
    parameter int unsigned WAIT_CYCLES = 6,
    parameter int unsigned FIFO_DEPTH  = 8
) (
    input  logic               clk0,
    input  logic               rst_ni,
    input  logic               trans_valid_0_i,
    output logic               trans_ready_0_o,
    input  logic [ADDR_W-1:0]  trans_addr_0_i,
    input  logic [NR_CS-1:0]   trans_cs_0_i,
    input  logic               trans_write_0_i,
    input  logic [BURST_W-1:0] trans_burst_0_i,
    input  logic               tx_valid_0_i,
    output logic               tx_ready_0_o,
    input  logic [WORD_W-1:0]  tx_data_0_i,
    input  logic [1:0]         tx_strb_0_i,
    output logic               rx_valid_0_o,
    input  logic               rx_ready_0_i,
    output logic [WORD_W-1:0]  rx_data_0_o,
    input  logic               trans_valid_1_i,
    output logic               trans_ready_1_o,
    input  logic [ADDR_W-1:0]  trans_addr_1_i,
    input  logic [NR_CS-1:0]   trans_cs_1_i,
    input  logic               trans_write_1_i,
    input  logic [BURST_W-1:0] trans_burst_1_i,
    input  logic               tx_valid_1_i,
    output logic               tx_ready_1_o,
    input  logic [WORD_W-1:0]  tx_data_1_i,
    input  logic [1:0]         tx_strb_1_i,
    output logic               rx_valid_1_o,
    input  logic               rx_ready_1_i,
    output logic [WORD_W-1:0]  rx_data_1_o,
    // hyperbus
    output logic [NR_CS-1:0]   hyper_cs_no,
    output logic               hyper_ck_en_o,
    output logic [WORD_W-1:0]  hyper_dq_o,
    input  logic [WORD_W-1:0]  hyper_dq_i,
    output logic               hyper_dq_oe_o,
    output logic [1:0]         hyper_rwds_o,
    input  logic [1:0]         hyper_rwds_i,
    output logic               hyper_rwds_oe_o
);

    logic               trans_valid, trans_ready, trans_write;
    logic [ADDR_W-1:0]  trans_addr;
    logic [NR_CS-1:0]   trans_cs;
    logic [BURST_W-1:0] trans_burst;
    logic               tx_valid, tx_ready;
    logic [WORD_W-1:0]  tx_data;
    logic [1:0]         tx_strb;
    logic               push, fifo_not_full, fifo_valid, fifo_ready, done;
    logic [WORD_W-1:0]  push_data, fifo_data;

    hyper_arbiter #(
        .ADDR_W (ADDR_W), .BURST_W(BURST_W), .NR_CS(NR_CS)
    ) u_arbiter (
        .*,
        .phy_trans_valid_o(trans_valid), .phy_trans_ready_i(trans_ready),
        .phy_addr_o(trans_addr), .phy_cs_o(trans_cs),
        .phy_write_o(trans_write), .phy_burst_o(trans_burst),
        .phy_tx_valid_o(tx_valid), .phy_tx_ready_i(tx_ready),
        .phy_tx_data_o(tx_data), .phy_tx_strb_o(tx_strb),
        .fifo_valid_i(fifo_valid), .fifo_ready_o(fifo_ready),
        .fifo_data_i(fifo_data), .done_i(done)
    );

    hyper_phy #(
        .BURST_W(BURST_W), .NR_CS(NR_CS), .WAIT_CYCLES(WAIT_CYCLES)
    ) u_phy (
        .*,
        .trans_valid_i(trans_valid), .trans_ready_o(trans_ready),
        .trans_addr_i(trans_addr), .trans_cs_i(trans_cs),
        .trans_write_i(trans_write), .trans_burst_i(trans_burst),
        .tx_valid_i(tx_valid), .tx_ready_o(tx_ready),
        .tx_data_i(tx_data), .tx_strb_i(tx_strb),
        .push_o(push), .push_data_o(push_data),
        .fifo_ready_i(fifo_not_full), .done_o(done)
    );

    hyper_rx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_rx_fifo (
        .clk0(clk0), .rst_ni(rst_ni),
        .push_i(push), .push_data_i(push_data), .ready_o(fifo_not_full),
        .valid_o(fifo_valid), .ready_i(fifo_ready), .data_o(fifo_data)
    );

endmodule

`default_nettype wire

// ==== hyper_ram_model.sv ====
// behavioral hyperram for one chip select, used by the testbench
// counts clocked cycles from cs low; read data goes out with rwds high
`timescale 1ns/1ps
`default_nettype none

module hyper_ram_model import hyper_pkg::*; #(
    parameter int unsigned WAIT_CYCLES = 6,
    parameter int unsigned MEM_WORDS   = 256
) (
    input  logic              clk0,
    input  logic              cs_ni,
    input  logic              ck_en_i,
    input  logic [WORD_W-1:0] dq_i,
    input  logic [1:0]        rwds_i,  // byte mask on writes
    output logic [WORD_W-1:0] dq_o,
    output logic [1:0]        rwds_o
);

    localparam int unsigned LAT_END = 3 + 2 * WAIT_CYCLES;  // first data cycle
    localparam int unsigned IDX_W   = $clog2(MEM_WORDS);

    logic [WORD_W-1:0] mem [MEM_WORDS];
    hyper_ca_t         ca_q;
    int unsigned       edge_q;  // clocked cycles in this frame
    logic              data_phase;
    logic              rd_phase;
    logic [ADDR_W-1:0] word_addr;
    logic [IDX_W-1:0]  idx;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign data_phase = !cs_ni && (edge_q >= LAT_END);
    assign rd_phase   = data_phase && ca_q.fields.rw;
    assign word_addr  = {ca_q.fields.addr_hi, ca_q.fields.addr_lo}
                        + ADDR_W'(edge_q - LAT_END);
    assign idx        = word_addr[IDX_W-1:0];
    assign dq_o       = rd_phase ? mem[idx] : '0;  // idle bus reads as zero
    assign rwds_o     = rd_phase ? 2'b11 : 2'b00;

    always_ff @(posedge clk0) begin
        if (cs_ni) begin
            edge_q <= 0;
        end else if (ck_en_i) begin
            edge_q <= edge_q + 1;
            if (edge_q < 3) begin
                ca_q.beats[2 - edge_q] <= dq_i;
            end else if (data_phase && !ca_q.fields.rw) begin
                if (!rwds_i[0]) mem[idx][7:0] <= dq_i[7:0];
                if (!rwds_i[1]) mem[idx][15:8] <= dq_i[15:8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hyper_assertions.sv ====
// protocol checks on the hyperbus side of the phy, bound into hyper_phy
// each failure raises $error and is tallied for the testbench summary
`timescale 1ns/1ps
`default_nettype none

module hyper_assertions import hyper_pkg::*; #(
    parameter int unsigned BURST_W = 12,
    parameter int unsigned NR_CS   = 2
) (
    input logic               clk0,
    input logic               rst_ni,
    input logic [NR_CS-1:0]   hyper_cs_no,
    input logic               hyper_dq_oe_o,
    input logic               hyper_rwds_oe_o,
    input logic               trans_valid_i,
    input logic               trans_ready_o,
    input logic [ADDR_W-1:0]  trans_addr_i,
    input logic [NR_CS-1:0]   trans_cs_i,
    input logic               trans_write_i,
    input logic [BURST_W-1:0] trans_burst_i,
    input logic               done_o
);

    int fail_cnt = 0;  // read by the testbench at the end

    a_one_cs: assert property (@(posedge clk0) disable iff (!rst_ni)
        $onehot0(~hyper_cs_no))
        else begin
            $error("more than one chip select low");
            fail_cnt++;
        end

    a_dq_oe: assert property (@(posedge clk0) disable iff (!rst_ni)
        $rose(hyper_dq_oe_o) |-> !(&hyper_cs_no))
        else begin
            $error("dq driven outside a frame");
            fail_cnt++;
        end

    a_rwds_oe: assert property (@(posedge clk0) disable iff (!rst_ni)
        $rose(hyper_rwds_oe_o) |-> !(&hyper_cs_no))
        else begin
            $error("rwds driven outside a frame");
            fail_cnt++;
        end

    // request payload holds until the phy takes it
    a_trans_stable: assert property (@(posedge clk0) disable iff (!rst_ni)
        trans_valid_i && !trans_ready_o |=> trans_valid_i && $stable(trans_addr_i)
            && $stable(trans_cs_i) && $stable(trans_write_i) && $stable(trans_burst_i))
        else begin
            $error("transaction request changed before acceptance");
            fail_cnt++;
        end

    a_done_pulse: assert property (@(posedge clk0) disable iff (!rst_ni)
        done_o |=> !done_o)
        else begin
            $error("done held longer than one cycle");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// clock and reset source for the hyperbus testbench
// reset is held for a few cycles and then released just after an edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int unsigned HALF_PERIOD  = 10,  // ns, 20 ns period
    parameter int unsigned RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 rst_no = 1'b1;  // same skew as the other inputs
    end

endmodule

`default_nettype wire

// ==== tb_hyper_subsystem.sv ====
// testbench for the hyperbus subsystem with two ram models on the bus
// write/read bursts from both ports are checked against a reference memory
`timescale 1ns/1ps
`default_nettype none

module tb_hyper_subsystem import hyper_pkg::*; ();

    localparam int unsigned BURST_W     = 12;
    localparam int unsigned NR_CS       = 2;
    localparam int unsigned WAIT_CYCLES = 6;
    localparam int unsigned FIFO_DEPTH  = 8;
    localparam int          TIMEOUT     = 300;  // cycles allowed per wait

    logic               clk0;
    logic               rst_ni;
    logic [1:0]         trans_valid, trans_ready, trans_write;
    logic [1:0]         tx_valid, tx_ready, rx_valid, rx_ready;
    logic [ADDR_W-1:0]  trans_addr [2];
    logic [NR_CS-1:0]   trans_cs [2];
    logic [BURST_W-1:0] trans_burst [2];
    logic [WORD_W-1:0]  tx_data [2];
    logic [1:0]         tx_strb [2];
    logic [WORD_W-1:0]  rx_data [2];
    logic [NR_CS-1:0]   cs_n;
    logic               ck_en, dq_oe, rwds_oe;
    logic [WORD_W-1:0]  dq_out, dq_in, ram0_dq, ram1_dq;
    logic [1:0]         rwds_out, rwds_in, ram0_rwds, ram1_rwds;

    logic [WORD_W-1:0]  ref_mem [NR_CS][256];  // expected ram contents
    logic [15:0]        lfsr;
    int                 errors;
    int                 timeouts;
    int                 grant_log [$];

    tb_clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(5)) u_clock_gen (
        .clk_o(clk0), .rst_no(rst_ni)
    );

    hyper_subsystem #(
        .BURST_W(BURST_W), .NR_CS(NR_CS), .WAIT_CYCLES(WAIT_CYCLES), .FIFO_DEPTH(FIFO_DEPTH)
    ) uut (
        .clk0(clk0), .rst_ni(rst_ni),
        .trans_valid_0_i(trans_valid[0]), .trans_ready_0_o(trans_ready[0]),
        .trans_addr_0_i(trans_addr[0]), .trans_cs_0_i(trans_cs[0]),
        .trans_write_0_i(trans_write[0]), .trans_burst_0_i(trans_burst[0]),
        .tx_valid_0_i(tx_valid[0]), .tx_ready_0_o(tx_ready[0]),
        .tx_data_0_i(tx_data[0]), .tx_strb_0_i(tx_strb[0]),
        .rx_valid_0_o(rx_valid[0]), .rx_ready_0_i(rx_ready[0]), .rx_data_0_o(rx_data[0]),
        .trans_valid_1_i(trans_valid[1]), .trans_ready_1_o(trans_ready[1]),
        .trans_addr_1_i(trans_addr[1]), .trans_cs_1_i(trans_cs[1]),
        .trans_write_1_i(trans_write[1]), .trans_burst_1_i(trans_burst[1]),
        .tx_valid_1_i(tx_valid[1]), .tx_ready_1_o(tx_ready[1]),
        .tx_data_1_i(tx_data[1]), .tx_strb_1_i(tx_strb[1]),
        .rx_valid_1_o(rx_valid[1]), .rx_ready_1_i(rx_ready[1]), .rx_data_1_o(rx_data[1]),
        .hyper_cs_no(cs_n), .hyper_ck_en_o(ck_en),
        .hyper_dq_o(dq_out), .hyper_dq_i(dq_in), .hyper_dq_oe_o(dq_oe),
        .hyper_rwds_o(rwds_out), .hyper_rwds_i(rwds_in), .hyper_rwds_oe_o(rwds_oe)
    );

    hyper_ram_model #(.WAIT_CYCLES(WAIT_CYCLES)) u_ram0 (
        .clk0(clk0), .cs_ni(cs_n[0]), .ck_en_i(ck_en), .dq_i(dq_out),
        .rwds_i(rwds_out), .dq_o(ram0_dq), .rwds_o(ram0_rwds)
    );

    hyper_ram_model #(.WAIT_CYCLES(WAIT_CYCLES)) u_ram1 (
        .clk0(clk0), .cs_ni(cs_n[1]), .ck_en_i(ck_en), .dq_i(dq_out),
        .rwds_i(rwds_out), .dq_o(ram1_dq), .rwds_o(ram1_rwds)
    );

    assign dq_in   = ram0_dq | ram1_dq;  // idle model drives zero
    assign rwds_in = ram0_rwds | ram1_rwds;

    bind hyper_phy hyper_assertions #(.BURST_W(BURST_W), .NR_CS(NR_CS)) u_assertions (
        .clk0(clk0), .rst_ni(rst_ni), .hyper_cs_no(hyper_cs_no),
        .hyper_dq_oe_o(hyper_dq_oe_o), .hyper_rwds_oe_o(hyper_rwds_oe_o),
        .trans_valid_i(trans_valid_i), .trans_ready_o(trans_ready_o),
        .trans_addr_i(trans_addr_i), .trans_cs_i(trans_cs_i),
        .trans_write_i(trans_write_i), .trans_burst_i(trans_burst_i), .done_o(done_o)
    );

    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[14:0], fb};
        end
        return r;
    endfunction

    task automatic report_and_finish();
        int afails;
        afails = uut.u_phy.u_assertions.fail_cnt;
        $display("summary: %0d value errors, %0d assertion failures, %0d timeouts",
                 errors, afails, timeouts);
        if (errors == 0 && afails == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        timeouts++;
        $display("timeout: no %s within %0d cycles, at %0t ns", what, TIMEOUT, $time);
        report_and_finish();
    endtask

    task automatic check_word(input string what, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // called at posedge+2, returns at posedge+2 after the accepting edge
    task automatic send_trans(input int p, input int cs, input logic [7:0] addr,
                              input logic wr, input int n);
        int t;
        trans_valid[p] = 1'b1;
        trans_addr[p]  = ADDR_W'(addr);
        trans_cs[p]    = NR_CS'(1) << cs;
        trans_write[p] = wr;
        trans_burst[p] = BURST_W'(n);
        t = 0;
        @(negedge clk0);
        while (!trans_ready[p]) begin
            t++;
            if (t > TIMEOUT) timeout_abort("transaction acceptance");
            @(negedge clk0);
        end
        @(posedge clk0);
        #2;
        trans_valid[p] = 1'b0;
        grant_log.push_back(p);
    endtask

    task automatic write_burst(input int p, input int cs, input logic [7:0] addr, input int n,
                               input bit rand_strb, input bit gaps);
        logic [WORD_W-1:0] data;
        logic [1:0]        strb;
        logic [7:0]        idx;
        int                t;
        send_trans(p, cs, addr, 1'b1, n);
        for (int i = 0; i < n; i++) begin
            data = rand_bits(16);
            strb = rand_strb ? 2'(rand_bits(2)) : 2'b11;
            if (gaps && (i % 2 == 1)) begin
                tx_valid[p] = 1'b0;  // one stalled bus cycle
                @(posedge clk0);
                #2;
            end
            tx_valid[p] = 1'b1;
            tx_data[p]  = data;
            tx_strb[p]  = strb;
            t = 0;
            @(negedge clk0);
            while (!tx_ready[p]) begin
                t++;
                if (t > TIMEOUT) timeout_abort("write data acceptance");
                @(negedge clk0);
            end
            @(posedge clk0);
            #2;
            idx = addr + 8'(i);
            if (strb[0]) ref_mem[cs][idx][7:0] = data[7:0];
            if (strb[1]) ref_mem[cs][idx][15:8] = data[15:8];
        end
        tx_valid[p] = 1'b0;
    endtask

    task automatic read_burst(input int p, input int cs, input logic [7:0] addr, input int n,
                              input int hold);
        logic [7:0] idx;
        int         t;
        send_trans(p, cs, addr, 1'b0, n);
        if (hold > 0) begin
            repeat (hold) @(posedge clk0);  // lets the fifo fill up
            #2;
        end
        rx_ready[p] = 1'b1;
        for (int i = 0; i < n; i++) begin
            t = 0;
            @(negedge clk0);
            while (!rx_valid[p]) begin
                t++;
                if (t > TIMEOUT) timeout_abort("read data word");
                @(negedge clk0);
            end
            idx = addr + 8'(i);
            check_word($sformatf("port %0d cs %0d word %0d", p, cs, i), rx_data[p],
                       ref_mem[cs][idx]);
            // this word belongs to port p alone
            assert (rx_valid[1-p] === 1'b0) else begin
                errors++;
                $display("[ERROR] %0t ns port %0d sees read data of port %0d",
                         $time, 1 - p, p);
            end
            @(posedge clk0);
            #2;
        end
        rx_ready[p] = 1'b0;
    endtask

    initial begin
        logic [7:0] a;
        int         t;
        trans_valid = '0;
        trans_write = '0;
        tx_valid    = '0;
        rx_ready    = '0;
        for (int p = 0; p < 2; p++) begin
            trans_addr[p]  = '0;
            trans_cs[p]    = '0;
            trans_burst[p] = '0;
            tx_data[p]     = '0;
            tx_strb[p]     = '0;
        end
        for (int c = 0; c < NR_CS; c++) begin
            for (int i = 0; i < 256; i++) ref_mem[c][i] = '0;  // models start cleared
        end
        lfsr     = 16'd54;
        errors   = 0;
        timeouts = 0;

        t = 0;
        while (rst_ni !== 1'b1) begin
            t++;
            if (t > TIMEOUT) timeout_abort("reset release");
            @(posedge clk0);
        end
        @(negedge clk0);
        assert (cs_n == '1 && !dq_oe && !rwds_oe && !ck_en && rx_valid == 2'b00
                && trans_ready == 2'b00 && tx_ready == 2'b00) else begin
            errors++;
            $display("[ERROR] %0t ns bus not idle after reset: cs_n %b oe %b%b ck_en %b rx %b",
                     $time, cs_n, dq_oe, rwds_oe, ck_en, rx_valid);
        end
        @(posedge clk0);
        #2;

        // plain write then read back
        a = 8'(rand_bits(8));
        write_burst(0, 0, a, 8, 1'b0, 1'b0);
        read_burst(0, 0, a, 8, 0);

        // partial strobes over a full write
        a = 8'(rand_bits(8));
        write_burst(0, 1, a, 6, 1'b0, 1'b0);
        write_burst(0, 1, a, 6, 1'b1, 1'b0);
        read_burst(0, 1, a, 6, 0);

        // same address on both chips
        a = 8'(rand_bits(8));
        write_burst(1, 0, a, 4, 1'b0, 1'b0);
        write_burst(1, 1, a, 4, 1'b0, 1'b0);
        read_burst(0, 0, a, 4, 0);
        read_burst(1, 1, a, 4, 0);

        // both ports reading at once
        write_burst(0, 0, 8'h40, 5, 1'b0, 1'b0);
        write_burst(1, 0, 8'hc0, 5, 1'b0, 1'b0);
        grant_log.delete();
        fork
            begin
                read_burst(0, 0, 8'h40, 5, 0);
                read_burst(0, 0, 8'h40, 5, 0);
            end
            begin
                read_burst(1, 0, 8'hc0, 5, 0);
                read_burst(1, 0, 8'hc0, 5, 0);
            end
        join
        assert (grant_log.size() == 4 && grant_log[0] == 0 && grant_log[1] == 1
                && grant_log[2] == 0 && grant_log[3] == 1) else begin
            errors++;
            $display("[ERROR] %0t ns grants did not alternate between the ports", $time);
        end

        // back-pressure on both data channels
        a = 8'(rand_bits(8));
        write_burst(0, 0, a, 20, 1'b0, 1'b1);
        read_burst(0, 0, a, 20, 40);

        @(negedge clk0);
        assert (rx_valid == 2'b00) else begin
            errors++;
            $display("[ERROR] %0t ns extra read words left: rx_valid %b", $time, rx_valid);
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hyper_pkg.sv
hyper_rx_fifo.sv
hyper_arbiter.sv
hyper_phy.sv
hyper_subsystem.sv
hyper_ram_model.sv
hyper_assertions.sv
tb_clock_gen.sv
tb_hyper_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_hyper_subsystem
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  := TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
